// File: offload_settings.svh
// --------------------
// Offload complex settings
// Widths, unit count and multiply depth shared by all blocks
// --------------------
`ifndef OFFLOAD_SETTINGS_SVH
`define OFFLOAD_SETTINGS_SVH

// Operand and result width
`define OFFLOAD_DATA_W 32
// Transaction id width
`define OFFLOAD_ID_W 5
// Op word width, same as offload_pkg::offload_op_u
`define OFFLOAD_OP_W 4

// Units behind the dispatcher and the target width they need
`define OFFLOAD_NUM_UNITS 2
`define OFFLOAD_TGT_W $clog2(`OFFLOAD_NUM_UNITS)
`define OFFLOAD_TGT_MUL 0
`define OFFLOAD_TGT_BIT 1

// Multiply pipeline depth
`define OFFLOAD_MUL_STAGES 2

`endif

// File: offload_pkg.sv
// --------------------
// Offload types
// Op word as read by the multiply and bit units
// --------------------
package offload_pkg;

  // One op word with two readings
  // The dispatcher never looks inside, each unit picks its own view
  typedef union packed {
    // Multiply view
    struct packed {
      logic rsvd;
      // Operand b taken as signed
      logic signed_b;
      // Operand a taken as signed
      logic signed_a;
      // Upper 32 bits of the product
      logic high_half;
    } mul_view;
    // Bit-manipulation view
    struct packed {
      logic       rsvd;
      // 0 sll, 1 srl, 2 sra, 3 popcount, 4 clz
      // 5 to 7 undefined
      logic [2:0] kind;
    } bit_view;
  } offload_op_u;

endpackage

// File: spill_register.sv
// --------------------
// Spill register
// Two-entry valid/ready slice that cuts data and handshake paths
// --------------------
`timescale 1ns/1ps

module spill_register #(
  parameter int WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic             out_full_q, spill_full_q;
  logic [WIDTH-1:0] out_data_q, spill_data_q;
  logic             in_take;
  logic             out_load;

  // Accept while the spill slot is free
  assign ready_o  = !spill_full_q;
  assign in_take  = valid_i && ready_o;
  // Output slot refills when empty or drained this cycle
  assign out_load = !out_full_q || ready_i;

  assign valid_o = out_full_q;
  assign data_o  = out_data_q;

  // Slot occupancy
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      out_full_q   <= 1'b0;
      spill_full_q <= 1'b0;
    end else if (out_load) begin
      // Spilled item is older and leaves first
      out_full_q   <= spill_full_q || in_take;
      spill_full_q <= 1'b0;
    end else if (in_take) begin
      spill_full_q <= 1'b1;
    end
  end

  // Slot contents
  always_ff @(posedge clk_i) begin
    if (out_load) begin
      out_data_q <= spill_full_q ? spill_data_q : data_i;
    end
    if (!out_load && in_take) begin
      spill_data_q <= data_i;
    end
  end

  // Stalled output holds both valid and data
  a_hold_out: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// File: offload_dispatch.sv
// --------------------
// Offload dispatcher
// Steers requests by target, merges unit responses round-robin
// --------------------
`timescale 1ns/1ps
`include "offload_settings.svh"

module offload_dispatch (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Request from the request cut
  input  logic                       req_valid_i,
  input  logic [`OFFLOAD_TGT_W-1:0]  req_target_i,
  output logic                       req_ready_o,
  // Request handshake per unit
  output logic                       mul_valid_o,
  input  logic                       mul_ready_i,
  output logic                       bit_valid_o,
  input  logic                       bit_ready_i,
  // Multiply unit response
  input  logic [`OFFLOAD_DATA_W-1:0] mul_data_i,
  input  logic [`OFFLOAD_ID_W-1:0]   mul_id_i,
  input  logic                       mul_valid_i,
  output logic                       mul_accept_o,
  // Bit unit response
  input  logic [`OFFLOAD_DATA_W-1:0] bit_data_i,
  input  logic [`OFFLOAD_ID_W-1:0]   bit_id_i,
  input  logic                       bit_error_i,
  input  logic                       bit_valid_i,
  output logic                       bit_accept_o,
  // Merged response toward the response cut
  output logic [`OFFLOAD_DATA_W-1:0] resp_data_o,
  output logic [`OFFLOAD_ID_W-1:0]   resp_id_o,
  output logic                       resp_error_o,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i
);

  localparam int TGT_W = `OFFLOAD_TGT_W;
  localparam logic [TGT_W-1:0] TGT_MUL = TGT_W'(`OFFLOAD_TGT_MUL);
  localparam logic [TGT_W-1:0] TGT_BIT = TGT_W'(`OFFLOAD_TGT_BIT);

  // Grant select, high picks the bit unit
  logic gnt_bit;
  // Bit unit wins the next tie
  logic prio_bit_q;
  // Winner held while its response waits
  logic lock_q, lock_bit_q;

  // --------------------
  // Request demux
  // --------------------
  assign mul_valid_o = req_valid_i && (req_target_i == TGT_MUL);
  assign bit_valid_o = req_valid_i && (req_target_i == TGT_BIT);
  assign req_ready_o = (req_target_i == TGT_BIT) ? bit_ready_i : mul_ready_i;

  // --------------------
  // Response arbiter
  // --------------------
  always_comb begin
    if (lock_q) begin
      gnt_bit = lock_bit_q;
    end else if (mul_valid_i && bit_valid_i) begin
      gnt_bit = prio_bit_q;
    end else begin
      // Single requester or none
      gnt_bit = bit_valid_i;
    end
  end

  assign resp_valid_o = gnt_bit ? bit_valid_i : mul_valid_i;
  assign resp_data_o  = gnt_bit ? bit_data_i : mul_data_i;
  assign resp_id_o    = gnt_bit ? bit_id_i : mul_id_i;
  // Multiplies never fail
  assign resp_error_o = gnt_bit && bit_error_i;

  assign mul_accept_o = resp_ready_i && !gnt_bit;
  assign bit_accept_o = resp_ready_i && gnt_bit;

  // Pointer and lock
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      prio_bit_q <= 1'b0;
      lock_q     <= 1'b0;
      lock_bit_q <= 1'b0;
    end else if (resp_valid_o) begin
      lock_q     <= !resp_ready_i;
      lock_bit_q <= gnt_bit;
      // Winner drops to lowest priority once taken
      if (resp_ready_i) begin
        prio_bit_q <= !gnt_bit;
      end
    end
  end

  // Stalled winner keeps the response slot until taken
  a_grant_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && (gnt_bit == $past(gnt_bit)));

endmodule

// File: mul_unit.sv
// --------------------
// Multiply unit
// Two-stage 32x32 multiplier, low or high half, signed or unsigned
// --------------------
`timescale 1ns/1ps
`include "offload_settings.svh"

module mul_unit (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  input  logic [`OFFLOAD_ID_W-1:0]   id_i,
  input  offload_pkg::offload_op_u   op_i,
  input  logic [`OFFLOAD_DATA_W-1:0] arga_i,
  input  logic [`OFFLOAD_DATA_W-1:0] argb_i,
  output logic                       valid_o,
  input  logic                       ready_i,
  output logic [`OFFLOAD_DATA_W-1:0] data_o,
  output logic [`OFFLOAD_ID_W-1:0]   id_o
);

  localparam int DW     = `OFFLOAD_DATA_W;
  localparam int STAGES = `OFFLOAD_MUL_STAGES;

  // Stage valids, bit 0 is the product stage
  logic [STAGES-1:0]        vld_q;
  logic                     advance;
  // Operands widened by one bit that carries the sign
  logic [DW:0]              a_ext, b_ext;
  logic signed [2*DW+1:0]   prod;
  // Stage one payload
  logic [2*DW-1:0]          prod_q;
  logic                     high_q;
  logic [`OFFLOAD_ID_W-1:0] id1_q;
  // Stage two payload
  logic [DW-1:0]            res_q;
  logic [`OFFLOAD_ID_W-1:0] id2_q;

  // Whole pipe moves or whole pipe waits
  assign advance = !vld_q[STAGES-1] || ready_i;
  assign ready_o = advance;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[STAGES-2:0], valid_i};
    end
  end

  // --------------------
  // Stage one
  // --------------------
  assign a_ext = {op_i.mul_view.signed_a && arga_i[DW-1], arga_i};
  assign b_ext = {op_i.mul_view.signed_b && argb_i[DW-1], argb_i};
  assign prod  = $signed(a_ext) * $signed(b_ext);

  always_ff @(posedge clk_i) begin
    if (advance) begin
      prod_q <= prod[2*DW-1:0];
      high_q <= op_i.mul_view.high_half;
      id1_q  <= id_i;
      // Stage two picks the half
      res_q  <= high_q ? prod_q[2*DW-1:DW] : prod_q[DW-1:0];
      id2_q  <= id1_q;
    end
  end

  assign valid_o = vld_q[STAGES-1];
  assign data_o  = res_q;
  assign id_o    = id2_q;

  // Nothing comes out right after reset
  a_rst_quiet: assert property (@(posedge clk_i) $past(rst_i) |-> !valid_o);

endmodule

// File: bit_unit.sv
// --------------------
// Bit-manipulation unit
// Shifts, popcount and leading-zero count in one registered stage
// --------------------
`timescale 1ns/1ps
`include "offload_settings.svh"

module bit_unit (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  input  logic [`OFFLOAD_ID_W-1:0]   id_i,
  input  offload_pkg::offload_op_u   op_i,
  input  logic [`OFFLOAD_DATA_W-1:0] arga_i,
  input  logic [`OFFLOAD_DATA_W-1:0] argb_i,
  output logic                       valid_o,
  input  logic                       ready_i,
  output logic [`OFFLOAD_DATA_W-1:0] data_o,
  output logic [`OFFLOAD_ID_W-1:0]   id_o,
  output logic                       error_o
);

  localparam int DW   = `OFFLOAD_DATA_W;
  localparam int SH_W = $clog2(DW);
  // Kind codes of the bit view
  localparam logic [2:0] KIND_SLL = 3'd0;
  localparam logic [2:0] KIND_SRL = 3'd1;
  localparam logic [2:0] KIND_SRA = 3'd2;
  localparam logic [2:0] KIND_POP = 3'd3;
  localparam logic [2:0] KIND_CLZ = 3'd4;

  logic [SH_W-1:0]          shamt;
  logic [DW-1:0]            pop_cnt, lz_cnt, res_d;
  logic                     err_d;
  // Output register
  logic                     vld_q, err_q;
  logic [DW-1:0]            res_q;
  logic [`OFFLOAD_ID_W-1:0] id_q;

  assign shamt = argb_i[SH_W-1:0];

  // Population count
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < DW; i++) begin
      pop_cnt = pop_cnt + DW'(arga_i[i]);
    end
  end

  // Leading zeros, highest set bit wins, all-zero gives DW
  always_comb begin
    lz_cnt = DW'(DW);
    for (int i = 0; i < DW; i++) begin
      if (arga_i[i]) begin
        lz_cnt = DW'(DW - 1 - i);
      end
    end
  end

  // Result select
  always_comb begin
    res_d = '0;
    err_d = 1'b0;
    case (op_i.bit_view.kind)
      KIND_SLL: res_d = arga_i << shamt;
      KIND_SRL: res_d = arga_i >> shamt;
      KIND_SRA: res_d = $signed(arga_i) >>> shamt;
      KIND_POP: res_d = pop_cnt;
      KIND_CLZ: res_d = lz_cnt;
      // Undefined kinds answer zero
      default:  err_d = 1'b1;
    endcase
  end

  // New item enters in the cycle the old one leaves
  assign ready_o = !vld_q || ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      vld_q <= 1'b0;
    end else if (ready_o) begin
      vld_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      res_q <= res_d;
      err_q <= err_d;
      id_q  <= id_i;
    end
  end

  assign valid_o = vld_q;
  assign data_o  = res_q;
  assign error_o = err_q;
  assign id_o    = id_q;

  // Error responses carry no data
  a_err_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && error_o |-> data_o == '0);

endmodule

// File: offload_cc.sv
// --------------------
// Offload complex top
// Request cut, dispatcher, multiply and bit units, response cut
// --------------------
`timescale 1ns/1ps
`include "offload_settings.svh"

module offload_cc (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`OFFLOAD_TGT_W-1:0]  req_target_i,
  input  logic [`OFFLOAD_ID_W-1:0]   req_id_i,
  input  offload_pkg::offload_op_u   req_op_i,
  input  logic [`OFFLOAD_DATA_W-1:0] req_arga_i,
  input  logic [`OFFLOAD_DATA_W-1:0] req_argb_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output logic [`OFFLOAD_DATA_W-1:0] resp_data_o,
  output logic [`OFFLOAD_ID_W-1:0]   resp_id_o,
  output logic                       resp_error_o,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i
);
  import offload_pkg::*;

  localparam int DW     = `OFFLOAD_DATA_W;
  localparam int IW     = `OFFLOAD_ID_W;
  localparam int REQ_W  = `OFFLOAD_TGT_W + IW + `OFFLOAD_OP_W + 2 * DW;
  localparam int RESP_W = DW + IW + 1;

  // Request behind the cut
  logic [REQ_W-1:0]          req_q;
  logic                      req_q_valid, req_q_ready;
  logic [`OFFLOAD_TGT_W-1:0] req_q_target;
  logic [IW-1:0]             req_q_id;
  offload_op_u               req_q_op;
  logic [DW-1:0]             req_q_arga, req_q_argb;
  // Unit handshakes and responses
  logic                      mul_req_valid, mul_req_ready, bit_req_valid, bit_req_ready;
  logic [DW-1:0]             mul_data, bit_data;
  logic [IW-1:0]             mul_id, bit_id;
  logic                      mul_valid, mul_accept, bit_valid, bit_accept, bit_error;
  // Merged response ahead of the cut
  logic [DW-1:0]             arb_data;
  logic [IW-1:0]             arb_id;
  logic                      arb_error, arb_valid, arb_ready;
  logic [RESP_W-1:0]         resp_q;

  // Request path cut
  spill_register #(.WIDTH (REQ_W)) u_req_cut (
    .clk_i, .rst_i,
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  ({req_target_i, req_id_i, req_op_i, req_arga_i, req_argb_i}),
    .valid_o (req_q_valid),
    .ready_i (req_q_ready),
    .data_o  (req_q)
  );

  assign {req_q_target, req_q_id, req_q_op, req_q_arga, req_q_argb} = req_q;

  offload_dispatch u_dispatch (
    .clk_i, .rst_i,
    .req_valid_i  (req_q_valid),
    .req_target_i (req_q_target),
    .req_ready_o  (req_q_ready),
    .mul_valid_o  (mul_req_valid),
    .mul_ready_i  (mul_req_ready),
    .bit_valid_o  (bit_req_valid),
    .bit_ready_i  (bit_req_ready),
    .mul_data_i   (mul_data),
    .mul_id_i     (mul_id),
    .mul_valid_i  (mul_valid),
    .mul_accept_o (mul_accept),
    .bit_data_i   (bit_data),
    .bit_id_i     (bit_id),
    .bit_error_i  (bit_error),
    .bit_valid_i  (bit_valid),
    .bit_accept_o (bit_accept),
    .resp_data_o  (arb_data),
    .resp_id_o    (arb_id),
    .resp_error_o (arb_error),
    .resp_valid_o (arb_valid),
    .resp_ready_i (arb_ready)
  );

  mul_unit u_mul_unit (
    .clk_i, .rst_i,
    .valid_i (mul_req_valid),
    .ready_o (mul_req_ready),
    .id_i    (req_q_id),
    .op_i    (req_q_op),
    .arga_i  (req_q_arga),
    .argb_i  (req_q_argb),
    .valid_o (mul_valid),
    .ready_i (mul_accept),
    .data_o  (mul_data),
    .id_o    (mul_id)
  );

  bit_unit u_bit_unit (
    .clk_i, .rst_i,
    .valid_i (bit_req_valid),
    .ready_o (bit_req_ready),
    .id_i    (req_q_id),
    .op_i    (req_q_op),
    .arga_i  (req_q_arga),
    .argb_i  (req_q_argb),
    .valid_o (bit_valid),
    .ready_i (bit_accept),
    .data_o  (bit_data),
    .id_o    (bit_id),
    .error_o (bit_error)
  );

  // Response path cut
  spill_register #(.WIDTH (RESP_W)) u_resp_cut (
    .clk_i, .rst_i,
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  ({arb_data, arb_id, arb_error}),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i),
    .data_o  (resp_q)
  );

  assign {resp_data_o, resp_id_o, resp_error_o} = resp_q;

endmodule

// File: tb_offload_vectors.svh
// --------------------
// Offload testbench vectors
// Request rows with expected data and error, id is the row index
// --------------------
`ifndef TB_OFFLOAD_VECTORS_SVH
`define TB_OFFLOAD_VECTORS_SVH

localparam int NUM_VEC = 16;
localparam int ROW_W   = 1 + 4 + 32 + 32 + 32 + 1;

// Row layout {target, op, arga, argb, expected data, expected error}
// Target 0 is the multiply unit, target 1 the bit unit
// Mul op bits {rsvd, signed_b, signed_a, high_half}
// Bit op bits {rsvd, kind[2:0]}
function automatic logic [ROW_W-1:0] table_row(input int idx);
  logic [ROW_W-1:0] row;
  case (idx)
    // Unsigned low, 3 * 5
    0:  row = {1'b0, 4'b0000, 32'h0000_0003, 32'h0000_0005, 32'h0000_000f, 1'b0};
    // Shift left by 4
    1:  row = {1'b1, 4'b0000, 32'h0000_00f1, 32'h0000_0004, 32'h0000_0f10, 1'b0};
    // Unsigned high of max * max
    2:  row = {1'b0, 4'b0001, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 1'b0};
    // Logical right, only argb[4:0] counts so 0x3f shifts by 31
    3:  row = {1'b1, 4'b0001, 32'h8000_0000, 32'h0000_003f, 32'h0000_0001, 1'b0};
    // Signed high, -1 * -1 is 1
    4:  row = {1'b0, 4'b0111, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 1'b0};
    // Arithmetic right fills with sign
    5:  row = {1'b1, 4'b0010, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 1'b0};
    // Signed low, -2 * 3
    6:  row = {1'b0, 4'b0110, 32'hffff_fffe, 32'h0000_0003, 32'hffff_fffa, 1'b0};
    // Popcount, 4 + 4 + 1 bits
    7:  row = {1'b1, 4'b0011, 32'hf0f0_0001, 32'h0000_0000, 32'h0000_0009, 1'b0};
    // Signed a times unsigned b, high half
    8:  row = {1'b0, 4'b0011, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 1'b0};
    // Leading zeros with bit 16 as top set bit
    9:  row = {1'b1, 4'b0100, 32'h0001_0000, 32'h0000_0000, 32'h0000_000f, 1'b0};
    // Unsigned high, 2^31 * 4
    10: row = {1'b0, 4'b0001, 32'h8000_0000, 32'h0000_0004, 32'h0000_0002, 1'b0};
    // Leading zeros of zero is the full width
    11: row = {1'b1, 4'b0100, 32'h0000_0000, 32'h0000_0000, 32'h0000_0020, 1'b0};
    // Undefined kinds answer zero with error
    12: row = {1'b1, 4'b0101, 32'h0000_1234, 32'h0000_0005, 32'h0000_0000, 1'b1};
    // Unsigned low of 2^32 drops out
    13: row = {1'b0, 4'b0000, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000, 1'b0};
    14: row = {1'b1, 4'b0111, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b1};
    15: row = {1'b1, 4'b0110, 32'hdead_beef, 32'h0000_0003, 32'h0000_0000, 1'b1};
    default: row = '0;
  endcase
  return row;
endfunction

`endif

// File: tb_offload_cc.sv
// --------------------
// Offload complex testbench
// Table-driven requests, id scoreboard, random response back-pressure
// --------------------
`timescale 1ns/1ps
`include "offload_settings.svh"

module tb_offload_cc;
  import offload_pkg::*;

  `include "tb_offload_vectors.svh"

  // Both passes of the table plus slack
  localparam int TIMEOUT_CYCLES = 40 * NUM_VEC * 2 + 100;

  logic                       clk_i;
  logic                       rst_i;
  logic [`OFFLOAD_TGT_W-1:0]  req_target_i;
  logic [`OFFLOAD_ID_W-1:0]   req_id_i;
  offload_op_u                req_op_i;
  logic [`OFFLOAD_DATA_W-1:0] req_arga_i, req_argb_i;
  logic                       req_valid_i, req_ready_o;
  logic [`OFFLOAD_DATA_W-1:0] resp_data_o;
  logic [`OFFLOAD_ID_W-1:0]   resp_id_o;
  logic                       resp_error_o, resp_valid_o, resp_ready_i;

  // Scoreboard, indexed by id
  logic   sent [NUM_VEC];
  logic   got [NUM_VEC];
  int     received = 0;
  int     cycles = 0;
  // Random response ready while high
  logic   stress = 1'b0;
  integer seed = 33751;

  offload_cc u_offload_cc (
    .clk_i, .rst_i,
    .req_target_i, .req_id_i, .req_op_i, .req_arga_i, .req_argb_i,
    .req_valid_i, .req_ready_o,
    .resp_data_o, .resp_id_o, .resp_error_o, .resp_valid_o, .resp_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // Present one row at the falling edge and hold it until taken
  task automatic send_row(input int idx);
    logic        tgt, e;
    logic [3:0]  op;
    logic [31:0] a, b, d;
    {tgt, op, a, b, d, e} = table_row(idx);
    @(negedge clk_i);
    req_target_i = tgt;
    req_id_i     = idx[`OFFLOAD_ID_W-1:0];
    req_op_i     = op;
    req_arga_i   = a;
    req_argb_i   = b;
    req_valid_i  = 1'b1;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    sent[idx] = 1'b1;
  endtask

  // Match one response against the row with its id
  task automatic check_response(input logic [`OFFLOAD_ID_W-1:0] id,
                                input logic [31:0] data, input logic err);
    logic        tgt, e;
    logic [3:0]  op;
    logic [31:0] a, b, d;
    if (id >= NUM_VEC || !sent[id]) begin
      abort_run($sformatf("Response with unknown id %0d", id));
    end
    if (got[id]) begin
      abort_run($sformatf("Response for id %0d arrived twice", id));
    end
    {tgt, op, a, b, d, e} = table_row(id);
    compare_value($sformatf("resp_data_o (id %0d)", id), data, d);
    compare_value($sformatf("resp_error_o (id %0d)", id), {31'b0, err}, {31'b0, e});
    got[id] = 1'b1;
    received++;
  endtask

  // Response monitor, a transfer is valid and ready at the rising edge
  always @(posedge clk_i) begin
    if (!rst_i && resp_valid_o && resp_ready_i) begin
      check_response(resp_id_o, resp_data_o, resp_error_o);
    end
  end

  // Ready driver, mostly low under stress
  always @(negedge clk_i) begin
    if (stress) begin
      resp_ready_i = (($random(seed) & 3) == 0);
    end else begin
      resp_ready_i = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, %0d responses seen", cycles, received));
    end
  end

  initial begin
    rst_i        = 1'b1;
    req_target_i = '0;
    req_id_i     = '0;
    req_op_i     = '0;
    req_arga_i   = '0;
    req_argb_i   = '0;
    req_valid_i  = 1'b0;
    resp_ready_i = 1'b1;
    for (int i = 0; i < NUM_VEC; i++) begin
      sent[i] = 1'b0;
      got[i]  = 1'b0;
    end
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;

    // Idle state out of reset
    @(negedge clk_i);
    compare_value("req_ready_o", {31'b0, req_ready_o}, 32'h1);
    compare_value("resp_valid_o", {31'b0, resp_valid_o}, 32'h0);

    // ----------------------
    // Back to back, no back-pressure
    for (int i = 0; i < NUM_VEC; i++) begin
      send_row(i);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (received < NUM_VEC) @(negedge clk_i);

    // ----------------------
    // Same table under random response stalls
    for (int i = 0; i < NUM_VEC; i++) begin
      sent[i] = 1'b0;
      got[i]  = 1'b0;
    end
    received = 0;
    @(posedge clk_i);
    stress = 1'b1;
    for (int i = 0; i < NUM_VEC; i++) begin
      send_row(i);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    @(posedge clk_i);
    stress = 1'b0;
    while (received < NUM_VEC) @(negedge clk_i);

    // Every row answered, nothing may be left behind the response cut
    compare_value("resp_valid_o", {31'b0, resp_valid_o}, 32'h0);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
offload_pkg.sv
spill_register.sv
offload_dispatch.sv
mul_unit.sv
bit_unit.sv
offload_cc.sv
tb_offload_cc.sv

// File: Bender.yml
package:
  name: offload_cc

sources:
  - include_dirs:
      - .
    files:
      - offload_pkg.sv
      - spill_register.sv
      - offload_dispatch.sv
      - mul_unit.sv
      - bit_unit.sv
      - offload_cc.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_offload_cc.sv
